//--- hdl/rob_defs.svh
// Sizing of the re-order buffer core
// ROB_INDEX_BITS must equal log2(ROB_ENTRIES) so that tickets wrap naturally
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// Entry count and ticket width
`define ROB_ENTRIES     8
`define ROB_INDEX_BITS  3

// Result word
`define ROB_DATA_WIDTH  32

// Completion and forwarding ports
`define ROB_FU_NUMBER   2
`define ROB_READ_PORTS  2

// Register and cause fields
`define ROB_LREG_BITS   5
`define ROB_PREG_BITS   6
`define ROB_CAUSE_BITS  4

`endif

//--- hdl/rob_pkg.sv
// Shared types of the re-order buffer, sized from rob_defs.svh
`include "rob_defs.svh"

package rob_pkg;

    // Entry index and occupancy
    typedef logic [`ROB_INDEX_BITS-1:0] ticket_t;
    typedef logic [`ROB_INDEX_BITS:0]   count_t;

    // Result payload
    typedef logic [`ROB_DATA_WIDTH-1:0] rob_data_t;

    // Register numbers
    typedef logic [`ROB_LREG_BITS-1:0]  lreg_t;
    typedef logic [`ROB_PREG_BITS-1:0]  preg_t;

    typedef logic [`ROB_CAUSE_BITS-1:0] cause_t;

    // One bit per entry
    typedef logic [`ROB_ENTRIES-1:0]    entry_vec_t;

    // Lifetime of an entry between allocation and commit
    typedef enum logic [1:0] {
        ENTRY_EMPTY,
        ENTRY_PENDING,
        ENTRY_DONE
    } entry_state_t;

endpackage

//--- hdl/rob_pointers.sv
// Head, tail and occupancy of the ROB
// Status comes from the registered count, so it lags a same-cycle commit by one cycle
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_pointers import rob_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    alloc_valid_1,
    input  logic    alloc_valid_2,
    input  logic    commit_valid,
    output ticket_t head,
    output ticket_t tail,
    output logic    rob_full,
    output logic    rob_two_empty
);

    count_t count;
    count_t alloc_num;

    // Slot 2 implies slot 1
    always_comb begin
        if (alloc_valid_2) begin
            alloc_num = count_t'(2);
        end else if (alloc_valid_1) begin
            alloc_num = count_t'(1);
        end else begin
            alloc_num = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= tail + ticket_t'(alloc_num);
            count <= count + alloc_num - count_t'(commit_valid);
            if (commit_valid) begin
                head <= head + 1'b1;
            end
        end
    end

    assign rob_full      = (count == count_t'(`ROB_ENTRIES));
    // At least two free entries
    assign rob_two_empty = (count <= count_t'(`ROB_ENTRIES - 2));

    // Issuer must respect the status it was given
    assert property (@(posedge clk) disable iff (!rst_n)
        (alloc_num != '0) |-> (count_t'(count + alloc_num) <= count_t'(`ROB_ENTRIES)))
        else $error("ROB allocation beyond free space");

    assert property (@(posedge clk) disable iff (!rst_n)
        alloc_valid_2 |-> alloc_valid_1)
        else $error("ROB slot 2 allocated without slot 1");

endmodule

//--- hdl/rob_entry_table.sv
// Control fields of every ROB entry and the retire decision for the head
// Updates must only target allocated entries; two updates never hit one ticket in a cycle
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_entry_table import rob_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  ticket_t head,
    input  ticket_t tail,
    input  logic    alloc_valid_1,
    input  logic    alloc_valid_2,
    input  logic    alloc_valid_dest_1,
    input  logic    alloc_valid_dest_2,
    input  lreg_t   alloc_lreg_1,
    input  lreg_t   alloc_lreg_2,
    input  preg_t   alloc_preg_1,
    input  preg_t   alloc_preg_2,
    input  preg_t   alloc_ppreg_1,
    input  preg_t   alloc_ppreg_2,
    input  logic    upd_valid [`ROB_FU_NUMBER],
    input  logic    upd_exception [`ROB_FU_NUMBER],
    input  ticket_t upd_ticket [`ROB_FU_NUMBER],
    input  cause_t  upd_cause [`ROB_FU_NUMBER],
    input  logic    flush_valid,
    input  entry_vec_t flush_mark,
    output logic    commit_valid,
    output logic    commit_write,
    output logic    commit_flushed,
    output logic    commit_exception,
    output cause_t  commit_cause,
    output lreg_t   commit_lreg,
    output preg_t   commit_preg,
    output preg_t   commit_ppreg
);

    entry_state_t state [`ROB_ENTRIES];
    logic         valid_dest [`ROB_ENTRIES];
    lreg_t        lreg [`ROB_ENTRIES];
    preg_t        preg [`ROB_ENTRIES];
    preg_t        ppreg [`ROB_ENTRIES];
    logic         exception [`ROB_ENTRIES];
    cause_t       cause [`ROB_ENTRIES];
    logic         flushed [`ROB_ENTRIES];

    ticket_t      tail_plus;
    entry_vec_t   alloc1_vec;
    entry_vec_t   alloc2_vec;
    entry_vec_t   upd_hit;
    logic         upd_exc_sel [`ROB_ENTRIES];
    cause_t       upd_cause_sel [`ROB_ENTRIES];

    assign tail_plus  = tail + 1'b1;
    assign alloc1_vec = alloc_valid_1 ? entry_vec_t'(1) << tail : '0;
    assign alloc2_vec = alloc_valid_2 ? entry_vec_t'(1) << tail_plus : '0;

    // Route each FU update to its entry
    always_comb begin
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            upd_hit[i]       = 1'b0;
            upd_exc_sel[i]   = 1'b0;
            upd_cause_sel[i] = '0;
            for (int j = 0; j < `ROB_FU_NUMBER; j++) begin
                if (upd_valid[j] && upd_ticket[j] == ticket_t'(i)) begin
                    upd_hit[i]       = 1'b1;
                    upd_exc_sel[i]   = upd_exception[j];
                    upd_cause_sel[i] = upd_cause[j];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ROB_ENTRIES; i++) begin
                state[i] <= ENTRY_EMPTY;
            end
        end else begin
            for (int i = 0; i < `ROB_ENTRIES; i++) begin
                if (alloc2_vec[i] || alloc1_vec[i]) begin
                    state[i] <= ENTRY_PENDING;
                end else if (commit_valid && head == ticket_t'(i)) begin
                    // Head leaves even if a late update arrives for it
                    state[i] <= ENTRY_EMPTY;
                end else if (upd_hit[i]) begin
                    state[i] <= ENTRY_DONE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            if (alloc2_vec[i]) begin
                valid_dest[i] <= alloc_valid_dest_2;
                lreg[i]       <= alloc_lreg_2;
                preg[i]       <= alloc_preg_2;
                ppreg[i]      <= alloc_ppreg_2;
                exception[i]  <= 1'b0;
                cause[i]      <= '0;
            end else if (alloc1_vec[i]) begin
                valid_dest[i] <= alloc_valid_dest_1;
                lreg[i]       <= alloc_lreg_1;
                preg[i]       <= alloc_preg_1;
                ppreg[i]      <= alloc_ppreg_1;
                exception[i]  <= 1'b0;
                cause[i]      <= '0;
            end else if (upd_hit[i]) begin
                exception[i]  <= upd_exc_sel[i];
                cause[i]      <= upd_cause_sel[i];
            end
        end
    end

    // Flush mark wins over the value written at allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            if (flush_valid && flush_mark[i]) begin
                flushed[i] <= 1'b1;
            end else if (alloc2_vec[i] || alloc1_vec[i]) begin
                flushed[i] <= flush_valid;
            end
        end
    end

    // Retire when done, or drain when flushed
    assign commit_valid     = (state[head] != ENTRY_EMPTY) &&
                              (state[head] == ENTRY_DONE || flushed[head]);
    assign commit_write     = commit_valid && valid_dest[head] && !flushed[head] &&
                              !exception[head];
    assign commit_flushed   = commit_valid && flushed[head];
    assign commit_exception = commit_valid && exception[head] && !flushed[head];
    assign commit_cause     = cause[head];
    assign commit_lreg      = lreg[head];
    assign commit_preg      = preg[head];
    assign commit_ppreg     = ppreg[head];

    for (genvar j = 0; j < `ROB_FU_NUMBER; j++) begin : g_upd_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            upd_valid[j] |-> (state[upd_ticket[j]] != ENTRY_EMPTY))
            else $error("FU %0d updated an empty ROB entry", j);
    end

endmodule

//--- hdl/rob_data_bank.sv
// Result storage with one write port per FU and combinational reads
// Extra read port is tied to the head for commit data
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_data_bank import rob_pkg::*; (
    input  logic      clk,
    input  logic      upd_valid [`ROB_FU_NUMBER],
    input  ticket_t   upd_ticket [`ROB_FU_NUMBER],
    input  rob_data_t upd_data [`ROB_FU_NUMBER],
    input  ticket_t   read_ticket [`ROB_READ_PORTS],
    input  ticket_t   head,
    output rob_data_t read_data [`ROB_READ_PORTS],
    output rob_data_t commit_data
);

    rob_data_t mem [`ROB_ENTRIES];
    ticket_t   rd_addr [`ROB_READ_PORTS+1];
    rob_data_t rd_data [`ROB_READ_PORTS+1];

    always_ff @(posedge clk) begin
        for (int j = 0; j < `ROB_FU_NUMBER; j++) begin
            if (upd_valid[j]) begin
                mem[upd_ticket[j]] <= upd_data[j];
            end
        end
    end

    // Forwarding ports first, head last
    always_comb begin
        for (int k = 0; k < `ROB_READ_PORTS; k++) begin
            rd_addr[k] = read_ticket[k];
        end
        rd_addr[`ROB_READ_PORTS] = head;
    end

    always_comb begin
        for (int k = 0; k <= `ROB_READ_PORTS; k++) begin
            rd_data[k] = mem[rd_addr[k]];
        end
    end

    always_comb begin
        for (int k = 0; k < `ROB_READ_PORTS; k++) begin
            read_data[k] = rd_data[k];
        end
    end

    assign commit_data = rd_data[`ROB_READ_PORTS];

endmodule

//--- hdl/rob_flush_mask.sv
// Marks the entries younger than the flush ticket, stopping at the head
// Never marks more than ROB_ENTRIES-1 entries, so the head itself is never marked
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_flush_mask import rob_pkg::*; (
    input  ticket_t    flush_ticket,
    input  ticket_t    head,
    output entry_vec_t flush_mark,
    output entry_vec_t flush_vector_inv
);

    ticket_t start;

    assign start = flush_ticket + 1'b1;

    always_comb begin : walk
        ticket_t idx;
        logic    reached;
        flush_mark = '0;
        reached    = 1'b0;
        for (int n = 0; n < `ROB_ENTRIES - 1; n++) begin
            idx = start + ticket_t'(n);
            // Wrapped around to the oldest entry
            if (idx == head) begin
                reached = 1'b1;
            end
            if (!reached) begin
                flush_mark[idx] = 1'b1;
            end
        end
    end

    assign flush_vector_inv = ~flush_mark;

endmodule

//--- hdl/rob_top.sv
// Re-order buffer core for a dual-issue pipeline
// Issuer allocates only within the reported free space
`timescale 1ns/10ps
`include "rob_defs.svh"

module rob_top import rob_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       alloc_valid_1,
    input  logic       alloc_valid_2,
    input  logic       alloc_valid_dest_1,
    input  logic       alloc_valid_dest_2,
    input  lreg_t      alloc_lreg_1,
    input  lreg_t      alloc_lreg_2,
    input  preg_t      alloc_preg_1,
    input  preg_t      alloc_preg_2,
    input  preg_t      alloc_ppreg_1,
    input  preg_t      alloc_ppreg_2,
    output ticket_t    alloc_ticket,
    output logic       rob_full,
    output logic       rob_two_empty,
    input  logic       upd_valid [`ROB_FU_NUMBER],
    input  ticket_t    upd_ticket [`ROB_FU_NUMBER],
    input  rob_data_t  upd_data [`ROB_FU_NUMBER],
    input  logic       upd_exception [`ROB_FU_NUMBER],
    input  cause_t     upd_cause [`ROB_FU_NUMBER],
    input  logic       flush_valid,
    input  ticket_t    flush_ticket,
    output entry_vec_t flush_vector_inv,
    input  ticket_t    read_ticket [`ROB_READ_PORTS],
    output rob_data_t  read_data [`ROB_READ_PORTS],
    output logic       commit_valid,
    output logic       commit_write,
    output logic       commit_flushed,
    output logic       commit_exception,
    output cause_t     commit_cause,
    output ticket_t    commit_ticket,
    output lreg_t      commit_lreg,
    output preg_t      commit_preg,
    output preg_t      commit_ppreg,
    output rob_data_t  commit_data
);

    ticket_t    head;
    entry_vec_t flush_mark;

    assign commit_ticket = head;

    // The tail is the ticket handed to slot 1
    rob_pointers u_pointers (.*, .tail(alloc_ticket));

    rob_entry_table u_entry_table (.*, .tail(alloc_ticket));

    rob_data_bank u_data_bank (.*);

    rob_flush_mask u_flush_mask (.*);

endmodule

//--- testbench/tb_clock_gen.sv
// Testbench clock, 20 ns period; reset held low for the first 2 cycles
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/tb_rob.sv
// Random testbench for rob_top, checked against a circular-buffer model of the ROB
// Allocates only within free space and completes only pending, unflushed entries
`timescale 1ns/10ps
`include "rob_defs.svh"

module tb_rob import rob_pkg::*; ();

    localparam int STIM_CYCLES  = 600;
    localparam int DRAIN_CYCLES = 40;
    localparam int CYCLE_LIMIT  = 4 * STIM_CYCLES;

    logic clk, rst_n;
    logic alloc_valid_1, alloc_valid_2, alloc_valid_dest_1, alloc_valid_dest_2;
    lreg_t alloc_lreg_1, alloc_lreg_2;
    preg_t alloc_preg_1, alloc_preg_2, alloc_ppreg_1, alloc_ppreg_2;
    ticket_t alloc_ticket;
    logic rob_full, rob_two_empty;
    logic upd_valid [`ROB_FU_NUMBER];
    ticket_t upd_ticket [`ROB_FU_NUMBER];
    rob_data_t upd_data [`ROB_FU_NUMBER];
    logic upd_exception [`ROB_FU_NUMBER];
    cause_t upd_cause [`ROB_FU_NUMBER];
    logic flush_valid;
    ticket_t flush_ticket;
    entry_vec_t flush_vector_inv;
    ticket_t read_ticket [`ROB_READ_PORTS];
    rob_data_t read_data [`ROB_READ_PORTS];
    logic commit_valid, commit_write, commit_flushed, commit_exception;
    cause_t commit_cause;
    ticket_t commit_ticket;
    lreg_t commit_lreg;
    preg_t commit_preg, commit_ppreg;
    rob_data_t commit_data;

    // Reference model
    entry_state_t m_state [`ROB_ENTRIES];
    logic m_dest [`ROB_ENTRIES];
    logic m_exc [`ROB_ENTRIES];
    logic m_flushed [`ROB_ENTRIES];
    logic m_written [`ROB_ENTRIES];
    lreg_t m_lreg [`ROB_ENTRIES];
    preg_t m_preg [`ROB_ENTRIES];
    preg_t m_ppreg [`ROB_ENTRIES];
    cause_t m_cause [`ROB_ENTRIES];
    rob_data_t m_data [`ROB_ENTRIES];
    ticket_t m_head, m_tail;
    int m_count;
    logic p_valid, p_write, p_flushed, p_exc;

    integer seed = 32'heb6f_b410;
    int errors = 0;
    int cycles = 0;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    rob_top u_dut (.*);

    function automatic int rnd(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Younger than the flush ticket and not yet wrapped to the head
    function automatic logic is_marked(input ticket_t ft, input ticket_t hd, input int i);
        ticket_t s;
        s = ft + 1'b1;
        return ticket_t'(ticket_t'(i) - s) < ticket_t'(hd - s);
    endfunction

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_ticket(input string what, input ticket_t got, input ticket_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_data(input string what, input rob_data_t got, input rob_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_preg(input string what, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_lreg(input string what, input lreg_t got, input lreg_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_cause(input string what, input cause_t got, input cause_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            errors++;
        end
    endtask

    // Commit outputs expected from the model head
    task automatic predict();
        p_valid   = m_state[m_head] == ENTRY_DONE ||
                    (m_state[m_head] == ENTRY_PENDING && m_flushed[m_head]);
        p_flushed = p_valid && m_flushed[m_head];
        p_write   = p_valid && m_dest[m_head] && !m_flushed[m_head] && !m_exc[m_head];
        p_exc     = p_valid && m_exc[m_head] && !m_flushed[m_head];
    endtask

    task automatic check_outputs();
        predict();
        check_bit("commit_valid", commit_valid, p_valid);
        check_bit("commit_write", commit_write, p_write);
        check_bit("commit_flushed", commit_flushed, p_flushed);
        check_bit("commit_exception", commit_exception, p_exc);
        if (p_valid) begin
            check_ticket("commit_ticket", commit_ticket, m_head);
            check_lreg("commit_lreg", commit_lreg, m_lreg[m_head]);
            check_preg("commit_preg", commit_preg, m_preg[m_head]);
            check_preg("commit_ppreg", commit_ppreg, m_ppreg[m_head]);
            if (!p_flushed) begin
                check_data("commit_data", commit_data, m_data[m_head]);
            end
            if (p_exc) begin
                check_cause("commit_cause", commit_cause, m_cause[m_head]);
            end
        end
        check_ticket("alloc_ticket", alloc_ticket, m_tail);
        check_bit("rob_full", rob_full, m_count == `ROB_ENTRIES);
        check_bit("rob_two_empty", rob_two_empty, m_count <= `ROB_ENTRIES - 2);
        for (int k = 0; k < `ROB_READ_PORTS; k++) begin
            if (m_written[read_ticket[k]]) begin
                check_data("read_data", read_data[k], m_data[read_ticket[k]]);
            end
        end
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            check_bit("flush_vector_inv", flush_vector_inv[i],
                      !is_marked(flush_ticket, m_head, i));
        end
    endtask

    task automatic alloc_entry(input ticket_t t, input logic dest, input lreg_t l,
                               input preg_t p, input preg_t pp);
        m_state[t]   = ENTRY_PENDING;
        m_dest[t]    = dest;
        m_lreg[t]    = l;
        m_preg[t]    = p;
        m_ppreg[t]   = pp;
        m_exc[t]     = 1'b0;
        m_cause[t]   = '0;
        m_flushed[t] = flush_valid;
    endtask

    // Apply the inputs seen at this edge to the model
    task automatic advance_model();
        entry_vec_t mark;
        ticket_t idx;
        predict();
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            mark[i] = flush_valid && is_marked(flush_ticket, m_head, i);
        end
        if (p_valid) begin
            m_state[m_head] = ENTRY_EMPTY;
            m_head++;
            m_count--;
        end
        for (int j = 0; j < `ROB_FU_NUMBER; j++) begin
            if (upd_valid[j]) begin
                idx            = upd_ticket[j];
                m_state[idx]   = ENTRY_DONE;
                m_exc[idx]     = upd_exception[j];
                m_cause[idx]   = upd_cause[j];
                m_data[idx]    = upd_data[j];
                m_written[idx] = 1'b1;
            end
        end
        if (alloc_valid_1) begin
            alloc_entry(m_tail, alloc_valid_dest_1, alloc_lreg_1, alloc_preg_1, alloc_ppreg_1);
            m_tail++;
            m_count++;
        end
        if (alloc_valid_2) begin
            alloc_entry(m_tail, alloc_valid_dest_2, alloc_lreg_2, alloc_preg_2, alloc_ppreg_2);
            m_tail++;
            m_count++;
        end
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            if (mark[i]) begin
                m_flushed[i] = 1'b1;
            end
        end
    endtask

    task automatic drive_inputs(input bit alloc_on);
        int n;
        ticket_t idx;
        ticket_t taken;
        logic taken_v;
        n = alloc_on ? rnd(3) : 0;
        if (n > `ROB_ENTRIES - m_count) begin
            n = `ROB_ENTRIES - m_count;
        end
        alloc_valid_1      <= n >= 1;
        alloc_valid_2      <= n == 2;
        alloc_valid_dest_1 <= rnd(4) != 0;
        alloc_valid_dest_2 <= rnd(4) != 0;
        alloc_lreg_1       <= lreg_t'(rnd(32));
        alloc_lreg_2       <= lreg_t'(rnd(32));
        alloc_preg_1       <= preg_t'(rnd(64));
        alloc_preg_2       <= preg_t'(rnd(64));
        alloc_ppreg_1      <= preg_t'(rnd(64));
        alloc_ppreg_2      <= preg_t'(rnd(64));
        // Each port scans from a random start for a pending, unflushed entry
        taken_v = 1'b0;
        taken   = '0;
        for (int j = 0; j < `ROB_FU_NUMBER; j++) begin
            upd_valid[j] <= 1'b0;
            idx = ticket_t'(rnd(`ROB_ENTRIES));
            for (int k = 0; k < `ROB_ENTRIES; k++) begin
                if (m_state[idx] == ENTRY_PENDING && !m_flushed[idx] &&
                    !(taken_v && idx == taken) && (!alloc_on || rnd(4) != 0)) begin
                    k = `ROB_ENTRIES;
                end else begin
                    idx++;
                end
            end
            if (m_state[idx] == ENTRY_PENDING && !m_flushed[idx] && !(taken_v && idx == taken)) begin
                upd_valid[j]     <= 1'b1;
                upd_ticket[j]    <= idx;
                upd_data[j]      <= rob_data_t'($random(seed));
                upd_exception[j] <= rnd(16) == 0;
                upd_cause[j]     <= cause_t'(rnd(16));
                taken   = idx;
                taken_v = 1'b1;
            end
        end
        for (int k = 0; k < `ROB_READ_PORTS; k++) begin
            read_ticket[k] <= ticket_t'(rnd(`ROB_ENTRIES));
        end
        // Flush behind an excepting head in the cycle it commits
        predict();
        flush_valid  <= p_exc;
        flush_ticket <= p_exc ? m_head : ticket_t'(rnd(`ROB_ENTRIES));
    endtask

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        alloc_valid_1 = 1'b0;
        alloc_valid_2 = 1'b0;
        alloc_valid_dest_1 = 1'b0;
        alloc_valid_dest_2 = 1'b0;
        alloc_lreg_1 = '0;
        alloc_lreg_2 = '0;
        alloc_preg_1 = '0;
        alloc_preg_2 = '0;
        alloc_ppreg_1 = '0;
        alloc_ppreg_2 = '0;
        flush_valid = 1'b0;
        flush_ticket = '0;
        for (int j = 0; j < `ROB_FU_NUMBER; j++) begin
            upd_valid[j] = 1'b0;
            upd_ticket[j] = '0;
            upd_data[j] = '0;
            upd_exception[j] = 1'b0;
            upd_cause[j] = '0;
        end
        for (int k = 0; k < `ROB_READ_PORTS; k++) begin
            read_ticket[k] = '0;
        end
        for (int i = 0; i < `ROB_ENTRIES; i++) begin
            m_state[i] = ENTRY_EMPTY;
            m_flushed[i] = 1'b0;
            m_written[i] = 1'b0;
        end
        m_head = '0;
        m_tail = '0;
        m_count = 0;
        wait (rst_n === 1'b1);
        // First pass checks the idle state out of reset
        for (int c = 0; c < STIM_CYCLES + DRAIN_CYCLES; c++) begin
            @(negedge clk);
            check_outputs();
            @(posedge clk);
            advance_model();
            drive_inputs(c < STIM_CYCLES);
        end
        if (m_count != 0) begin
            $display("ROB still holds %0d entries after the drain phase", m_count);
            errors++;
        end
        $display("Run complete after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_pointers.sv
hdl/rob_entry_table.sv
hdl/rob_data_bank.sv
hdl/rob_flush_mask.sv
hdl/rob_top.sv
testbench/tb_clock_gen.sv
testbench/tb_rob.sv

//--- Bender.yml
package:
  name: rob_core

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rob_pkg.sv
      - hdl/rob_pointers.sv
      - hdl/rob_entry_table.sv
      - hdl/rob_data_bank.sv
      - hdl/rob_flush_mask.sv
      - hdl/rob_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_rob.sv
